// File: glb_settings.svh
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// bank geometry
// byte address into one bank
`define GLB_ADDR_WIDTH 12
// one bank word
`define GLB_BANK_DATA_WIDTH 64
// bytes per word, also the address step of the dma
`define GLB_BANK_BYTES 8
// read enable to valid read data, in cycles
`define GLB_BANK_RD_LATENCY 2

// configuration bus
// upper half of a bank word
`define GLB_CFG_ADDR_WIDTH 32
// lower half of a bank word
`define GLB_CFG_DATA_WIDTH 32

// parallel config dma
// word count of one run
`define GLB_MAX_CFGS_WIDTH 9
// tiles in the chain
`define GLB_NUM_TILES 16
// configured chain latency
`define GLB_LATENCY_WIDTH 5
// fixed part of the done delay
`define GLB_PC_FIXED_LATENCY 6

`endif

// File: glb_pkg.sv
`default_nettype none

`include "glb_settings.svh"

package glb_pkg;

    // byte address into the bank
    typedef logic [`GLB_ADDR_WIDTH-1:0] glb_addr_t;

    // one bank word
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;

    // halves of a configuration bus write
    // cfg address sits in the upper bits of a bank word
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

    // words left in a run
    typedef logic [`GLB_MAX_CFGS_WIDTH-1:0] cfg_cnt_t;

    // chain latency, in tiles
    typedef logic [`GLB_LATENCY_WIDTH-1:0] pc_latency_t;

    // dma state
    typedef enum logic {
        PC_IDLE = 1'b0,
        PC_RUN  = 1'b1
    } pc_state_t;

endpackage

`default_nettype wire

// File: glb_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "glb_settings.svh"

module glb_bank (
    input  logic               clk,
    input  logic               reset,

    // host preload port
    input  logic               host_wr_en,
    input  glb_pkg::glb_addr_t  host_wr_addr,
    input  glb_pkg::bank_data_t host_wr_data,

    // read request from the dma
    input  logic               rd_en,
    input  glb_pkg::glb_addr_t  rd_addr,

    // read response, fixed latency
    output glb_pkg::bank_data_t rd_data,
    output logic               rd_data_valid
);

    // byte offset bits inside one word
    localparam int OFFSET_W = $clog2(`GLB_BANK_BYTES);
    // word index bits
    localparam int INDEX_W = `GLB_ADDR_WIDTH - OFFSET_W;
    localparam int DEPTH = 1 << INDEX_W;
    localparam int LAT = `GLB_BANK_RD_LATENCY;

    // word storage
    glb_pkg::bank_data_t mem [DEPTH];

    // word indices, byte offset dropped
    logic [INDEX_W-1:0] wr_idx;
    logic [INDEX_W-1:0] rd_idx;

    // read pipeline, stage 0 holds the raw array output
    logic                valid_pipe [LAT];
    glb_pkg::bank_data_t data_pipe  [LAT];

    assign wr_idx = host_wr_addr[`GLB_ADDR_WIDTH-1:OFFSET_W];
    assign rd_idx = rd_addr[`GLB_ADDR_WIDTH-1:OFFSET_W];

    // host write, visible to any read sampled on a later edge
    always_ff @(posedge clk) begin
        if (host_wr_en) begin
            mem[wr_idx] <= host_wr_data;
        end
    end

    // valid bits of the read pipeline
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < LAT; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= rd_en;
            for (int i = 1; i < LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // read data follows the valid bits
    always_ff @(posedge clk) begin
        // array only read on a real request
        if (rd_en) begin
            data_pipe[0] <= mem[rd_idx];
        end
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // last stage drives the response
    assign rd_data       = data_pipe[LAT-1];
    assign rd_data_valid = valid_pipe[LAT-1];

endmodule

`default_nettype wire

// File: glb_pc_dma.sv
`timescale 1ns/100ps
`default_nettype none

`include "glb_settings.svh"

module glb_pc_dma (
    input  logic               clk,
    input  logic               reset,

    // configuration fields
    input  logic               pc_dma_mode,
    input  logic               pc_start_pulse,
    input  glb_pkg::glb_addr_t  pc_start_addr,
    input  glb_pkg::cfg_cnt_t   pc_num_cfgs,

    // read request to the bank
    output logic               rd_en,
    output glb_pkg::glb_addr_t  rd_addr,

    // read response from the bank
    input  glb_pkg::bank_data_t rd_data,
    input  logic               rd_data_valid,

    // configuration bus
    output logic               cfg_wr_en,
    output glb_pkg::cfg_addr_t  cfg_addr,
    output glb_pkg::cfg_data_t  cfg_data,

    // end of run, before the chain delay
    output logic               done_raw
);

    // state and run bookkeeping
    glb_pkg::pc_state_t state;
    glb_pkg::pc_state_t state_next;
    logic               start_accept;
    logic               start_q;

    // words left and next word address
    glb_pkg::cfg_cnt_t  cnt;
    glb_pkg::cfg_cnt_t  cnt_next;
    glb_pkg::glb_addr_t addr;
    glb_pkg::glb_addr_t addr_next;

    // run phase conditions
    logic               issue;
    logic               last;

    // captured response word
    glb_pkg::bank_data_t rd_data_q;
    logic                rd_valid_q;

    // start only counts in pc mode and while idle
    // a start during a run is dropped
    assign start_accept = pc_dma_mode & pc_start_pulse & (state == glb_pkg::PC_IDLE)
                        & ~start_q;

    // one read per cycle while words are left
    assign issue = (state == glb_pkg::PC_RUN) & (cnt != '0);
    // counter empty, run ends on the next edge
    assign last  = (state == glb_pkg::PC_RUN) & (cnt == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_accept;
        end
    end

    // state transitions
    always_comb begin
        state_next = state;
        case (state)
            glb_pkg::PC_IDLE: begin
                if (start_q) begin
                    state_next = glb_pkg::PC_RUN;
                end
            end
            glb_pkg::PC_RUN: begin
                if (last) begin
                    state_next = glb_pkg::PC_IDLE;
                end
            end
            default: begin
                state_next = glb_pkg::PC_IDLE;
            end
        endcase
    end

    // counter and address stepping
    always_comb begin
        cnt_next  = cnt;
        addr_next = addr;
        if (start_q) begin
            cnt_next  = pc_num_cfgs;
            addr_next = pc_start_addr;
        end else if (issue) begin
            cnt_next  = cnt - `GLB_MAX_CFGS_WIDTH'(1);
            // wraps at the address width
            addr_next = addr + `GLB_ADDR_WIDTH'(`GLB_BANK_BYTES);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= glb_pkg::PC_IDLE;
            cnt      <= '0;
            rd_en    <= 1'b0;
            done_raw <= 1'b0;
        end else begin
            state    <= state_next;
            cnt      <= cnt_next;
            rd_en    <= issue;
            done_raw <= last;
        end
    end

    // address only meaningful alongside a strobe
    always_ff @(posedge clk) begin
        addr <= addr_next;
        if (issue) begin
            rd_addr <= addr;
        end
    end

    // response capture
    // trusted by its valid bit, only this dma reads the bank
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_data_valid) begin
            rd_data_q <= rd_data;
        end
    end

    // split onto the configuration bus
    assign cfg_wr_en = rd_valid_q;
    assign cfg_addr  = rd_data_q[`GLB_CFG_DATA_WIDTH +: `GLB_CFG_ADDR_WIDTH];
    assign cfg_data  = rd_data_q[0 +: `GLB_CFG_DATA_WIDTH];

endmodule

`default_nettype wire

// File: glb_done_delay.sv
`timescale 1ns/100ps
`default_nettype none

`include "glb_settings.svh"

module glb_done_delay (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pulse_in,
    input  glb_pkg::pc_latency_t pc_latency,
    output logic                 pulse_out
);

    // enough stages for the longest chain
    localparam int DEPTH = 2 * `GLB_NUM_TILES + `GLB_PC_FIXED_LATENCY;
    localparam int TAP_W = $clog2(DEPTH);

    // stage i holds the input delayed by i+1 cycles
    logic [DEPTH-1:0] line;

    // latency held to the chain length so the tap stays in range
    glb_pkg::pc_latency_t lat_c;
    logic [TAP_W-1:0]     tap_idx;

    assign lat_c = (pc_latency > `GLB_LATENCY_WIDTH'(`GLB_NUM_TILES)) ?
                   `GLB_LATENCY_WIDTH'(`GLB_NUM_TILES) : pc_latency;

    // 2 cycles per tile plus the fixed part, minus the stage offset
    assign tap_idx = TAP_W'({lat_c, 1'b0}) + TAP_W'(`GLB_PC_FIXED_LATENCY - 1);

    // never stalls, several pulses may be in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            line <= '0;
        end else begin
            line <= {line[DEPTH-2:0], pulse_in};
        end
    end

    assign pulse_out = line[tap_idx];

endmodule

`default_nettype wire

// File: glb_pc_tile.sv
`timescale 1ns/100ps
`default_nettype none

module glb_pc_tile (
    input  logic                 clk,
    input  logic                 reset,

    // host preload
    input  logic                 host_wr_en,
    input  glb_pkg::glb_addr_t    host_wr_addr,
    input  glb_pkg::bank_data_t   host_wr_data,

    // parallel config fields and kick
    input  logic                 pc_dma_mode,
    input  glb_pkg::glb_addr_t    pc_start_addr,
    input  glb_pkg::cfg_cnt_t     pc_num_cfgs,
    input  glb_pkg::pc_latency_t  pc_latency,
    input  logic                 pc_start_pulse,

    // configuration bus to the array
    output logic                 cfg_wr_en,
    output glb_pkg::cfg_addr_t    cfg_addr,
    output glb_pkg::cfg_data_t    cfg_data,

    // end of run, after the chain delay
    output logic                 pc_done_pulse
);

    // dma to bank
    logic                rd_en;
    glb_pkg::glb_addr_t  rd_addr;

    // bank to dma
    glb_pkg::bank_data_t rd_data;
    logic                rd_data_valid;

    // dma to done delay
    logic                done_raw;

    glb_bank u_bank (
        .clk           (clk),
        .reset         (reset),
        .host_wr_en    (host_wr_en),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    glb_pc_dma u_pc_dma (
        .clk            (clk),
        .reset          (reset),
        .pc_dma_mode    (pc_dma_mode),
        .pc_start_pulse (pc_start_pulse),
        .pc_start_addr  (pc_start_addr),
        .pc_num_cfgs    (pc_num_cfgs),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_data_valid  (rd_data_valid),
        .cfg_wr_en      (cfg_wr_en),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .done_raw       (done_raw)
    );

    // models the config bus travelling down the tile chain
    glb_done_delay u_done_delay (
        .clk        (clk),
        .reset      (reset),
        .pulse_in   (done_raw),
        .pc_latency (pc_latency),
        .pulse_out  (pc_done_pulse)
    );

endmodule

`default_nettype wire

// File: tb_glb_pc.sv
`timescale 1ns/100ps
`default_nettype none

`include "glb_settings.svh"

module tb_glb_pc;

    localparam int WORDS = (1 << `GLB_ADDR_WIDTH) / `GLB_BANK_BYTES;
    localparam int BYTES = `GLB_BANK_BYTES;
    localparam int TILES = `GLB_NUM_TILES;

    logic                 clk;
    logic                 reset;
    logic                 host_wr_en;
    glb_pkg::glb_addr_t   host_wr_addr;
    glb_pkg::bank_data_t  host_wr_data;
    logic                 pc_dma_mode;
    glb_pkg::glb_addr_t   pc_start_addr;
    glb_pkg::cfg_cnt_t    pc_num_cfgs;
    glb_pkg::pc_latency_t pc_latency;
    logic                 pc_start_pulse;
    logic                 cfg_wr_en;
    glb_pkg::cfg_addr_t   cfg_addr;
    glb_pkg::cfg_data_t   cfg_data;
    logic                 pc_done_pulse;

    // reference copy of the bank, one entry per word
    glb_pkg::bank_data_t model_mem [WORDS];

    // expected bus writes and done pulses, keyed by edge number
    glb_pkg::cfg_addr_t exp_addr_q [$];
    glb_pkg::cfg_data_t exp_data_q [$];
    int                 exp_edge_q [$];
    int                 exp_done_q [$];

    // edge counter, cycle limit, last edge on which the dma still reads
    int          cycle;
    int          budget;
    int          busy_until;
    logic        checking;
    string       test_name;
    logic [31:0] lfsr;

    glb_pc_tile u_dut (
        .clk            (clk),
        .reset          (reset),
        .host_wr_en     (host_wr_en),
        .host_wr_addr   (host_wr_addr),
        .host_wr_data   (host_wr_data),
        .pc_dma_mode    (pc_dma_mode),
        .pc_start_addr  (pc_start_addr),
        .pc_num_cfgs    (pc_num_cfgs),
        .pc_latency     (pc_latency),
        .pc_start_pulse (pc_start_pulse),
        .cfg_wr_en      (cfg_wr_en),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .pc_done_pulse  (pc_done_pulse)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // read in the active region this is the number of the current edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(16) % (hi - lo + 1));
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_cfg(input glb_pkg::cfg_addr_t exp_a, input glb_pkg::cfg_data_t exp_d,
                               input int exp_e, input glb_pkg::cfg_addr_t act_a,
                               input glb_pkg::cfg_data_t act_d, input int act_e);
        if (act_a !== exp_a || act_d !== exp_d || act_e != exp_e) begin
            fail_run($sformatf(
                "mismatch in %s: expected cfg %h %h at edge %0d, actual %h %h at edge %0d",
                test_name, exp_a, exp_d, exp_e, act_a, act_d, act_e));
        end
    endtask

    task automatic compare_done(input int exp_e, input int act_e);
        if (act_e != exp_e) begin
            fail_run($sformatf("mismatch in %s: expected done at edge %0d, actual edge %0d",
                               test_name, exp_e, act_e));
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        int edge_no;
        edge_no = cycle - 1;
        if (checking) begin
            if ($isunknown({cfg_wr_en, pc_done_pulse})) begin
                fail_run("configuration write enable or done pulse is unknown");
            end
            if (cfg_wr_en) begin
                if (exp_addr_q.size() == 0) begin
                    fail_run($sformatf("configuration write at edge %0d in %s was not expected",
                                       edge_no, test_name));
                end else begin
                    compare_cfg(exp_addr_q.pop_front(), exp_data_q.pop_front(),
                                exp_edge_q.pop_front(), cfg_addr, cfg_data, edge_no);
                end
            end
            if (pc_done_pulse) begin
                if (exp_done_q.size() == 0) begin
                    fail_run($sformatf("done pulse at edge %0d in %s was not expected",
                                       edge_no, test_name));
                end else begin
                    compare_done(exp_done_q.pop_front(), edge_no);
                end
            end
        end
    end

    // limit grows as each step of the test is scheduled
    always @(negedge clk) begin
        if (cycle > budget) begin
            $display("timeout: the run took more than %0d cycles", budget);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic idle_cycles(input int n);
        budget += n;
        repeat (n) @(posedge clk);
    endtask

    // host writes and new starts only after the last read of the current run
    task automatic wait_dma_idle();
        while (cycle < busy_until) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_drained();
        while (exp_done_q.size() != 0 || exp_addr_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // n random words from start on, offset bits random
    task automatic preload_range(input glb_pkg::glb_addr_t start, input int n);
        int                  idx;
        glb_pkg::bank_data_t d;
        budget += n + 2;
        for (int k = 0; k < n; k++) begin
            idx = (int'(start) / BYTES + k) % WORDS;
            d   = rand_bits(`GLB_BANK_DATA_WIDTH);
            @(posedge clk);
            host_wr_en   <= 1'b1;
            host_wr_addr <= glb_pkg::glb_addr_t'(idx * BYTES + rand_range(0, BYTES - 1));
            host_wr_data <= d;
            model_mem[idx] = d;
        end
        @(posedge clk);
        host_wr_en <= 1'b0;
    endtask

    // accepted start, expectations from the timing rules
    task automatic start_run(input glb_pkg::glb_addr_t start, input int n);
        glb_pkg::glb_addr_t  a;
        glb_pkg::bank_data_t w;
        int                  t;
        budget += 20 * (n + 2 * int'(pc_latency) + 12);
        @(posedge clk);
        // sampled on the next edge
        t = cycle + 1;
        pc_dma_mode    <= 1'b1;
        pc_start_pulse <= 1'b1;
        pc_start_addr  <= start;
        pc_num_cfgs    <= glb_pkg::cfg_cnt_t'(n);
        for (int k = 0; k < n; k++) begin
            a = start + glb_pkg::glb_addr_t'(k * BYTES);
            w = model_mem[a / BYTES];
            // upper half address, lower half value
            exp_addr_q.push_back(w[63:32]);
            exp_data_q.push_back(w[31:0]);
            exp_edge_q.push_back(t + 5 + k);
        end
        exp_done_q.push_back(t + n + 2 + 2 * int'(pc_latency) + `GLB_PC_FIXED_LATENCY);
        busy_until = t + n + 2;
        @(posedge clk);
        pc_start_pulse <= 1'b0;
    endtask

    // a start the dma has to drop
    task automatic stray_start(input logic mode);
        budget += 4;
        @(posedge clk);
        pc_dma_mode    <= mode;
        pc_start_pulse <= 1'b1;
        pc_start_addr  <= glb_pkg::glb_addr_t'(rand_bits(`GLB_ADDR_WIDTH));
        @(posedge clk);
        pc_start_pulse <= 1'b0;
        pc_dma_mode    <= 1'b1;
    endtask

    // tap only moves with no done pulse in the line
    // a pulse seen at the tap still walks the rest of the line
    task automatic set_latency(input int lat);
        wait_drained();
        idle_cycles(2 * TILES + `GLB_PC_FIXED_LATENCY);
        @(posedge clk);
        pc_latency <= glb_pkg::pc_latency_t'(lat);
    endtask

    task automatic random_run();
        glb_pkg::glb_addr_t start;
        int                 n;
        start = glb_pkg::glb_addr_t'(rand_bits(`GLB_ADDR_WIDTH));
        n     = rand_range(1, 40);
        wait_dma_idle();
        preload_range(start, n);
        start_run(start, n);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b0;
        host_wr_en     = 1'b0;
        host_wr_addr   = '0;
        host_wr_data   = '0;
        pc_dma_mode    = 1'b0;
        pc_start_addr  = '0;
        pc_num_cfgs    = '0;
        pc_latency     = '0;
        pc_start_pulse = 1'b0;
        cycle          = 0;
        budget         = 64;
        busy_until     = 0;
        checking       = 1'b0;
        lfsr           = 32'hce02_e35a;
        test_name      = "reset";

        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        checking = 1'b1;

        // bus and done must stay quiet without a start
        test_name = "idle_after_reset";
        idle_cycles(20);

        test_name = "full_preload";
        preload_range('0, WORDS);

        test_name = "random_run";
        set_latency(rand_range(0, TILES));
        random_run();
        wait_drained();

        test_name = "zero_count";
        start_run(glb_pkg::glb_addr_t'(rand_bits(`GLB_ADDR_WIDTH)), 0);
        wait_drained();

        // pc mode off, then a second start while running
        test_name = "ignored_starts";
        stray_start(1'b0);
        start_run(glb_pkg::glb_addr_t'(rand_bits(`GLB_ADDR_WIDTH)), rand_range(5, 20));
        stray_start(1'b1);
        wait_drained();
        idle_cycles(60);

        test_name = "latency_min";
        set_latency(0);
        random_run();

        test_name = "latency_max";
        set_latency(TILES);
        random_run();

        test_name = "latency_mid";
        for (int i = 0; i < 3; i++) begin
            set_latency(rand_range(1, TILES - 1));
            random_run();
        end

        // first done still in the delay line when the second run starts
        test_name = "back_to_back";
        set_latency(TILES);
        wait_dma_idle();
        start_run(glb_pkg::glb_addr_t'(rand_bits(`GLB_ADDR_WIDTH)), rand_range(1, 40));
        wait_dma_idle();
        start_run(glb_pkg::glb_addr_t'(rand_bits(`GLB_ADDR_WIDTH)), rand_range(1, 40));

        // groups of four runs share one latency
        test_name = "random_sequence";
        for (int r = 0; r < 12; r++) begin
            if (r % 4 == 0) begin
                set_latency(rand_range(0, TILES));
            end
            random_run();
        end
        wait_drained();
        idle_cycles(10);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
glb_pkg.sv
glb_bank.sv
glb_pc_dma.sv
glb_done_delay.sv
glb_pc_tile.sv
tb_glb_pc.sv

// File: Bender.yml
package:
  name: glb_pc_tile

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - glb_pkg.sv
      - glb_bank.sv
      - glb_pc_dma.sv
      - glb_done_delay.sv
      - glb_pc_tile.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_glb_pc.sv
